// File: list.f
rtl/denise_pkg.sv
rtl/denise_regs.sv
rtl/denise_beam.sv
rtl/denise_bitplanes.sv
rtl/denise_playfields.sv
rtl/denise_colortable.sv
rtl/denise.sv
dv/denise_checks.sv
dv/denise_tb.sv

// File: run.sh
#!/bin/sh
# build and run the display encoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
  --top-module denise_tb \
  -f list.f \
  -o sim_denise

./obj_dir/sim_denise > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: dv/denise_tb.sv
// ----------------------------------------------------------
// testbench for the display encoder
// drives wishbone writes, keeps a palette and plane model,
// and checks every pixel of a loaded word against it
// ----------------------------------------------------------
`timescale 1ns/1ps

module denise_tb import denise_pkg::*;;

  logic    clk;
  logic    reset;
  wb_req_t wb;
  logic    strhor;
  logic    blank;
  word_t   dat_r;
  logic    ack;
  rgb24_t  rgb;

  int       errors;
  color12_t pal [32];   // palette model
  word_t    words [6];  // plane words, index 0 is plane 1
  int       m_bpu;
  logic     m_dpf;
  logic     m_pf2pri;
  hpos_t    m_strt;
  hpos_t    m_stop;
  hpos_t    m_hpos;      // beam model
  logic     m_win;
  logic     m_d1;
  logic     m_d2;
  logic     m_d3;        // window seen by the lookup stage
  word_t    rd;

  denise #(.num_planes(6)) i_denise (
    .clk    (clk),
    .reset  (reset),
    .wb     (wb),
    .strhor (strhor),
    .blank  (blank),
    .dat_r  (dat_r),
    .ack    (ack),
    .rgb    (rgb)
  );

  bind denise denise_checks i_checks (
    .clk   (clk),
    .reset (reset),
    .wb    (wb),
    .ack   (ack),
    .dat_r (dat_r),
    .blank (blank),
    .rgb   (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns
  end

  // beam and window model, one stage deeper than window_del
  always @(posedge clk) begin
    if (reset) begin
      m_hpos <= '0;
      {m_win, m_d1, m_d2, m_d3} <= '0;
    end else begin
      if (strhor) m_hpos <= 9'd2;
      else m_hpos <= m_hpos + 9'd1;
      if (m_hpos == m_strt) m_win <= 1'b1;
      else if (m_hpos == m_stop) m_win <= 1'b0;
      m_d1 <= m_win;
      m_d2 <= m_d1;
      m_d3 <= m_d2;
    end
  end

  // line strobe in the last position of every line
  initial begin
    strhor = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      strhor = !reset && (m_hpos == 9'd455);
    end
  end

  // ----------------------------------------------------------
  // bus tasks
  // ----------------------------------------------------------
  task automatic wb_write(input reg_addr_t adr, input word_t dat);
    int n;
    n = 0;
    wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!ack && n < 20);
    if (!ack) begin
      errors++;
      $display("timeout waiting for ack on a write to %h", adr);
    end
    @(posedge clk);  // write lands on this edge
    #1;
    wb = '0;
  endtask

  task automatic wb_read(input reg_addr_t adr, output word_t dat);
    int n;
    n = 0;
    dat = '0;
    wb = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 16'h0000};
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!ack && n < 20);
    if (!ack) begin
      errors++;
      $display("timeout waiting for ack on a read of %h", adr);
    end
    dat = dat_r;
    @(posedge clk);  // request held through the ack edge
    #1;
    wb = '0;
  endtask

  task automatic wait_hpos(input hpos_t pos);
    int n;
    n = 0;
    while (m_hpos != pos && n < 1000) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (m_hpos != pos) begin
      errors++;
      $display("beam never reached position %0d", pos);
    end
  endtask

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  task automatic random_palette();
    word_t d;
    for (int i = 0; i < 32; i++) begin
      d = word_t'($urandom);
      pal[i] = d[11:0];  // top nibble is dropped
      wb_write(addr_color00 + reg_addr_t'(i), d);
    end
  endtask

  task automatic set_mode(input int bpu, input logic dpf, input logic pf2pri);
    m_bpu = bpu;
    m_dpf = dpf;
    m_pf2pri = pf2pri;
    wb_write(addr_bplcon0, word_t'({1'b0, 3'(bpu), 1'b0, dpf, 10'h000}));
    wb_write(addr_bplcon2, word_t'({pf2pri, 6'h00}));
  endtask

  // planes 2..6 into the holding registers, then the load
  task automatic load_words();
    for (int p = 1; p < 6; p++) begin
      wb_write(addr_bpl1dat + reg_addr_t'(p), words[p]);
    end
    wb_write(addr_bpl1dat, words[0]);
  endtask

  function automatic rgb24_t expected_pixel(input int k, input logic win, input logic blk);
    logic [5:0] b;
    logic [2:0] pf1;
    logic [2:0] pf2;
    logic [4:0] idx;
    logic       half;
    color12_t   c;
    rgb24_t     px;
    for (int p = 0; p < 6; p++) begin
      b[p] = (p < m_bpu) ? words[p][15-k] : 1'b0;
    end
    pf1 = {b[4], b[2], b[0]};
    pf2 = {b[5], b[3], b[1]};
    half = 1'b0;
    if (!win) begin
      idx = 5'd0;  // border
    end else if (!m_dpf) begin
      idx = b[4:0];
      half = b[5] && (m_bpu == 6);
    end else if (pf2 != 3'd0 && (m_pf2pri || pf1 == 3'd0)) begin
      idx = 5'd8 + 5'(pf2);
    end else begin
      idx = 5'(pf1);
    end
    c = pal[idx];
    if (half) c = {c[11:8] / 4'd2, c[7:4] / 4'd2, c[3:0] / 4'd2};
    px[23:16] = 8'(c[11:8]) * 8'd17;
    px[15:8]  = 8'(c[7:4]) * 8'd17;
    px[7:0]   = 8'(c[3:0]) * 8'd17;
    return blk ? 24'h000000 : px;
  endfunction

  // checks all 16 pixels of the word just loaded
  task automatic check_pixels(input bit use_blank);
    rgb24_t exp;
    for (int k = 0; k < 16; k++) begin
      @(posedge clk);
      #1;
      blank = use_blank && ($urandom % 4 == 0);
      #1;
      exp = expected_pixel(k, m_d3, blank);
      rgb_pixel: assert (rgb == exp) else begin
        errors++;
        $display("** Error: rgb = %h, expected %h at pixel %0d", rgb, exp, k);
      end
    end
    @(posedge clk);
    #1;
    blank = 1'b0;
  endtask

  task automatic random_line();
    for (int p = 0; p < 6; p++) words[p] = word_t'($urandom);
    load_words();
    check_pixels(1'b0);
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(32'h46c2));
    errors = 0;
    wb = '0;
    blank = 1'b0;
    reset = 1'b1;
    m_strt = 9'h000;
    m_stop = 9'h100;
    m_bpu = 0;
    m_dpf = 1'b0;
    m_pf2pri = 1'b0;
    for (int i = 0; i < 32; i++) pal[i] = '0;
    for (int p = 0; p < 6; p++) words[p] = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // reset state and the id register
    reset_rgb: assert (rgb == 24'h0 && !ack) else begin
      errors++;
      $display("** Error: rgb = %h, ack = %h, expected 000000 and 0", rgb, ack);
    end
    wb_read(addr_deniseid, rd);
    id_value: assert (rd == 16'hffff) else begin
      errors++;
      $display("** Error: dat_r = %h, expected ffff", rd);
    end

    // window open for the rest of the line and beyond
    wb_write(addr_diwstop, 16'h00ff);
    m_stop = 9'h1ff;

    // single playfield, plane count 1..5
    for (int bpu = 1; bpu <= 5; bpu++) begin
      random_palette();
      set_mode(bpu, 1'b0, 1'b0);
      repeat (2) random_line();
    end

    // bplcon0 holds a plane count now, still reads as zero
    wb_read(addr_bplcon0, rd);
    bplcon0_reads_zero: assert (rd == 16'h0000) else begin
      errors++;
      $display("** Error: dat_r = %h, expected 0000", rd);
    end

    // dual playfield, both priorities
    for (int pri = 0; pri < 2; pri++) begin
      set_mode(6, 1'b1, 1'(pri));
      repeat (4) random_line();
    end

    // extra half brite
    random_palette();
    set_mode(6, 1'b0, 1'b0);
    repeat (4) random_line();

    // window edges with blank mixed in
    set_mode(1, 1'b0, 1'b0);
    wb_write(addr_diwstrt, 16'h0040);
    m_strt = 9'h040;
    wb_write(addr_diwstop, 16'h0000);
    m_stop = 9'h100;
    words[0] = 16'hffff;
    wait_hpos(9'd248);  // close at 256
    wb_write(addr_bpl1dat, words[0]);
    check_pixels(1'b1);
    wait_hpos(9'd56);   // open at 64 on the next line
    wb_write(addr_bpl1dat, words[0]);
    check_pixels(1'b1);

    repeat (4) @(posedge clk);
    $display("errors: testbench %0d, bound checks %0d", errors, i_denise.i_checks.errors);
    if (errors == 0 && i_denise.i_checks.errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: dv/denise_checks.sv
// ----------------------------------------------------------
// protocol checks bound into the display encoder top level
// watches the wishbone port and the blank path
// ----------------------------------------------------------
`timescale 1ns/1ps

module denise_checks import denise_pkg::*; (
  input logic    clk,
  input logic    reset,
  input wb_req_t wb,
  input logic    ack,
  input word_t   dat_r,
  input logic    blank,
  input rgb24_t  rgb
);

  int errors;

  initial begin
    errors = 0;
  end

  // ----------------------------------------------------------
  // wishbone handshake
  // ----------------------------------------------------------
  // one ack per transfer
  ack_one_cycle: assert property (
    @(posedge clk) disable iff (reset)
    ack |=> !ack
  ) else begin
    errors++;
    $error("ack stayed high for two cycles in a row");
  end

  // no ack outside a bus cycle
  ack_needs_cyc: assert property (
    @(posedge clk) disable iff (reset)
    ack |-> (wb.cyc && wb.stb)
  ) else begin
    errors++;
    $error("ack came while cyc or stb was low");
  end

  // read data only while ack
  dat_r_idle_zero: assert property (
    @(posedge clk) disable iff (reset)
    !ack |-> (dat_r == 16'h0000)
  ) else begin
    errors++;
    $error("dat_r = %h, expected 0000 without ack", dat_r);
  end

  // ----------------------------------------------------------
  // video output
  // ----------------------------------------------------------
  // blank is black, whatever the pipe holds
  blank_forces_black: assert property (
    @(posedge clk) disable iff (reset)
    blank |-> (rgb == 24'h000000)
  ) else begin
    errors++;
    $error("rgb = %h, expected 000000 under blank", rgb);
  end

  // nothing on the output while reset holds
  reset_black: assert property (
    @(posedge clk)
    reset |=> (rgb == 24'h000000) || reset
  ) else begin
    errors++;
    $error("rgb = %h, expected 000000 after reset", rgb);
  end

endmodule

// File: rtl/denise.sv
// ----------------------------------------------------------
// display encoder top level
// register slave on wishbone classic, one lores pixel of
// 24 bit rgb per clk; num_planes sets the shifter count
// ----------------------------------------------------------
`timescale 1ns/1ps

module denise import denise_pkg::*; #(
  parameter int num_planes = 6
) (
  input  logic    clk,
  input  logic    reset,
  input  wb_req_t wb,
  input  logic    strhor,  // start of line
  input  logic    blank,
  output word_t   dat_r,
  output logic    ack,
  output rgb24_t  rgb
);

  reg_wr_t               wr;
  vid_ctrl_t             ctrl;
  hpos_t                 hdiwstrt;
  hpos_t                 hdiwstop;
  logic                  window_del;
  logic [num_planes-1:0] planes;
  logic                  ehb_en;
  clut_idx_t             select;

  denise_regs i_regs (
    .clk      (clk),
    .reset    (reset),
    .wb       (wb),
    .dat_r    (dat_r),
    .ack      (ack),
    .wr       (wr),
    .ctrl     (ctrl),
    .hdiwstrt (hdiwstrt),
    .hdiwstop (hdiwstop)
  );

  denise_beam i_beam (
    .clk        (clk),
    .reset      (reset),
    .strhor     (strhor),
    .hdiwstrt   (hdiwstrt),
    .hdiwstop   (hdiwstop),
    .window_del (window_del)
  );

  denise_bitplanes #(.num_planes(num_planes)) i_bitplanes (
    .clk    (clk),
    .reset  (reset),
    .wr     (wr),
    .bpu    (ctrl.bpu),
    .dpf    (ctrl.dpf),
    .planes (planes),
    .ehb_en (ehb_en)
  );

  denise_playfields #(.num_planes(num_planes)) i_playfields (
    .planes (planes),
    .dpf    (ctrl.dpf),
    .pf2pri (ctrl.pf2pri),
    .window (window_del),
    .select (select)
  );

  denise_colortable i_colortable (
    .clk    (clk),
    .reset  (reset),
    .wr     (wr),
    .select (select),
    .ehb_en (ehb_en),
    .blank  (blank),
    .rgb    (rgb)
  );

endmodule

// File: rtl/denise_colortable.sv
// ----------------------------------------------------------
// 32 entry colour table
// written through the colour registers; the lookup is
// registered, then halved for ehb, widened to 24 bits, and
// blanked combinationally
// ----------------------------------------------------------
`timescale 1ns/1ps

module denise_colortable import denise_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_wr_t   wr,
  input  clut_idx_t select,
  input  logic      ehb_en,  // honour the half flag
  input  logic      blank,   // forces black at once
  output rgb24_t    rgb
);

  color12_t   palette [32];
  logic       pal_wr;
  logic [4:0] pal_idx;
  color12_t   entry_q;  // looked-up entry
  logic       half_q;   // ehb halving for that entry
  logic [3:0] r;
  logic [3:0] g;
  logic [3:0] b;

  // ----------------------------------------------------------
  // palette writes
  // ----------------------------------------------------------
  assign pal_wr  = wr.valid && (wr.adr >= addr_color00) && (wr.adr <= addr_color31);
  assign pal_idx = 5'(wr.adr - addr_color00);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        palette[i] <= '0;
      end
    end else if (pal_wr) begin
      palette[pal_idx] <= wr.dat[11:0];  // upper nibble ignored
    end
  end

  // ----------------------------------------------------------
  // lookup stage
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      entry_q <= '0;
      half_q  <= 1'b0;
    end else begin
      entry_q <= palette[select[4:0]];
      half_q  <= select[5] && ehb_en;
    end
  end

  always_comb begin
    r = entry_q[11:8];
    g = entry_q[7:4];
    b = entry_q[3:0];
    if (half_q) begin
      r = r >> 1;  // half brightness per component
      g = g >> 1;
      b = b >> 1;
    end
    // n * 17 is the nibble repeated
    rgb = blank ? 24'h000000 : {r, r, g, g, b, b};
  end

endmodule

// File: rtl/denise_playfields.sv
// ----------------------------------------------------------
// playfield combiner
// turns the serial plane bits into a palette select for
// single or dual playfield; border forces entry 0
// ----------------------------------------------------------
`timescale 1ns/1ps

module denise_playfields import denise_pkg::*; #(
  parameter int num_planes = 6
) (
  input  logic [num_planes-1:0] planes,
  input  logic                  dpf,     // dual playfield
  input  logic                  pf2pri,  // playfield 2 in front
  input  logic                  window,  // delayed display window
  output clut_idx_t             select
);

  logic [5:0] pl;   // plane bits padded to six
  logic [2:0] pf1;  // odd planes 1, 3, 5
  logic [2:0] pf2;  // even planes 2, 4, 6

  always_comb begin
    pl = '0;
    pl[num_planes-1:0] = planes;
    pf1 = {pl[4], pl[2], pl[0]};
    pf2 = {pl[5], pl[3], pl[1]};

    if (!window) begin
      select = '0;  // border colour
    end else if (!dpf) begin
      select = clut_idx_t'(pl);  // plane 6 lands on the half flag
    end else if ((pf2 != 3'd0) && (pf2pri || (pf1 == 3'd0))) begin
      select = {3'b001, pf2};  // pf2 -> entries 8..15
    end else begin
      select = {3'b000, pf1};  // pf1 -> entries 0..7, zero if both clear
    end
  end

endmodule

// File: rtl/denise_bitplanes.sv
// ----------------------------------------------------------
// bitplane holding registers and shifters
// bpl2dat.. park in holding registers; the bpl1dat write
// loads all shifters at once and latches the plane count
// ----------------------------------------------------------
`timescale 1ns/1ps

module denise_bitplanes import denise_pkg::*; #(
  parameter int num_planes = 6  // 4 to 6
) (
  input  logic                  clk,
  input  logic                  reset,
  input  reg_wr_t               wr,
  input  bpu_t                  bpu,     // live plane count from bplcon0
  input  logic                  dpf,
  output logic [num_planes-1:0] planes,  // serial bit per plane, msb first
  output logic                  ehb_en   // six planes, single playfield
);

  word_t      hold  [1:num_planes-1];  // plane 1 loads straight from the bus
  word_t      shift [num_planes];
  bpu_t       l_bpu;                   // count latched at load
  logic       load;
  logic       hold_wr;
  logic [2:0] hold_idx;

  // ----------------------------------------------------------
  // write decode
  // ----------------------------------------------------------
  assign load     = wr.valid && (wr.adr == addr_bpl1dat);
  assign hold_idx = 3'(wr.adr - addr_bpl1dat);  // plane number - 1
  assign hold_wr  = wr.valid && (wr.adr > addr_bpl1dat) && (wr.adr <= addr_bpl6dat)
                    && (hold_idx < num_planes);

  always_ff @(posedge clk) begin
    if (hold_wr) begin
      hold[hold_idx] <= wr.dat;
    end
  end

  // ----------------------------------------------------------
  // shifters
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_planes; i++) begin
        shift[i] <= '0;
      end
      l_bpu <= '0;
    end else if (load) begin
      shift[0] <= wr.dat;  // bpl1dat word itself
      for (int i = 1; i < num_planes; i++) begin
        shift[i] <= hold[i];
      end
      l_bpu <= bpu;
    end else begin
      for (int i = 0; i < num_planes; i++) begin
        shift[i] <= {shift[i][14:0], 1'b0};  // one lores pixel per clk
      end
    end
  end

  // planes at or above the latched count read as zero
  always_comb begin
    for (int i = 0; i < num_planes; i++) begin
      planes[i] = shift[i][15] && (i < int'(l_bpu));
    end
  end

  // ehb only with exactly six planes outside dual playfield
  assign ehb_en = (l_bpu == 3'd6) && !dpf;

endmodule

// File: rtl/denise_beam.sv
// ----------------------------------------------------------
// horizontal beam counter and display window
// strhor restarts the line; the window flag is delayed two
// stages so it lines up with pixels leaving the shifters
// ----------------------------------------------------------
`timescale 1ns/1ps

module denise_beam import denise_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  strhor,      // horizontal strobe
  input  hpos_t hdiwstrt,
  input  hpos_t hdiwstop,
  output logic  window_del   // window aligned to the pixel pipe
);

  localparam hpos_t hpos_max = 9'd455;  // last lores pixel of a line

  hpos_t hpos;
  logic  window;
  logic  window_d1;

  // counts 2..455 when strhor arrives every line
  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= '0;
    end else if (strhor) begin
      hpos <= 9'd2;
    end else begin
      hpos <= hpos + 9'd1;
    end
  end

  // start match wins over stop match
  always_ff @(posedge clk) begin
    if (reset) begin
      window    <= 1'b0;
      window_d1 <= 1'b0;
      window_del <= 1'b0;
    end else begin
      if (hpos == hdiwstrt) begin
        window <= 1'b1;
      end else if (hpos == hdiwstop) begin
        window <= 1'b0;
      end
      window_d1  <= window;     // shifter stage
      window_del <= window_d1;  // playfield select stage
    end
  end

  // beam stays inside one pal line
  hpos_in_line: assert property (
    @(posedge clk) disable iff (reset)
    hpos <= hpos_max
  );

endmodule

// File: rtl/denise_regs.sv
// ----------------------------------------------------------
// wishbone classic register slave
// acks every request one cycle after cyc/stb, turns writes
// into a one-cycle strobe and holds the control registers
// ----------------------------------------------------------
`timescale 1ns/1ps

module denise_regs import denise_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  wb_req_t   wb,        // request from the master
  output word_t     dat_r,     // read data, zero unless ack
  output logic      ack,
  output reg_wr_t   wr,        // write strobe to the video blocks
  output vid_ctrl_t ctrl,
  output hpos_t     hdiwstrt,  // window start, bit 8 always 0
  output hpos_t     hdiwstop   // window stop, bit 8 always 1
);

  word_t bplcon0;
  word_t bplcon2;
  logic  rd_id;  // read of the chip id

  // ----------------------------------------------------------
  // handshake
  // ----------------------------------------------------------
  // single-cycle ack, never back to back
  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= wb.cyc && wb.stb && !ack;
    end
  end

  // master holds adr/dat until ack, so the strobe can use them directly
  assign wr.valid = ack && wb.we;
  assign wr.adr   = wb.adr;
  assign wr.dat   = wb.dat;

  // only deniseid answers, ocs id is all ones
  assign rd_id = ack && !wb.we && (wb.adr == addr_deniseid);
  assign dat_r = rd_id ? 16'hffff : 16'h0000;

  // ----------------------------------------------------------
  // control registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      bplcon0  <= '0;
      bplcon2  <= '0;
      hdiwstrt <= 9'h000;
      hdiwstop <= 9'h100;
    end else if (wr.valid) begin
      case (wr.adr)
        addr_bplcon0: bplcon0 <= wr.dat;
        addr_bplcon2: bplcon2 <= wr.dat;
        addr_diwstrt: hdiwstrt <= {1'b0, wr.dat[7:0]};  // h8 forced low
        addr_diwstop: hdiwstop <= {1'b1, wr.dat[7:0]};  // h8 forced high
        default: ;
      endcase
    end
  end

  // decode into the fields the video path uses
  assign ctrl.bpu    = bplcon0[14:12];
  assign ctrl.dpf    = bplcon0[10];
  assign ctrl.pf2pri = bplcon2[6];

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // one ack per transfer, even with stb held
  ack_single_cycle: assert property (
    @(posedge clk) disable iff (reset)
    ack |=> !ack
  );

  // ack never appears outside a bus cycle
  ack_within_cyc: assert property (
    @(posedge clk) disable iff (reset)
    ack |-> wb.cyc
  );

endmodule

// File: rtl/denise_pkg.sv
// ----------------------------------------------------------
// shared types for the display encoder
// width typedefs, register word offsets and bus structs
// imported by every design module that needs them
// ----------------------------------------------------------
package denise_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  typedef logic [15:0] word_t;      // bus data word
  typedef logic [7:0]  reg_addr_t;  // byte offset bits 8..1
  typedef logic [11:0] color12_t;   // 4 bits each r, g, b
  typedef logic [23:0] rgb24_t;     // output pixel
  typedef logic [5:0]  clut_idx_t;  // [4:0] entry, [5] half-brite
  typedef logic [8:0]  hpos_t;      // lores beam position
  typedef logic [2:0]  bpu_t;       // bitplane count

  // ----------------------------------------------------------
  // register word offsets, written as byte offset >> 1
  // ----------------------------------------------------------
  localparam reg_addr_t addr_deniseid = reg_addr_t'(9'h07c >> 1);
  localparam reg_addr_t addr_diwstrt  = reg_addr_t'(9'h08e >> 1);
  localparam reg_addr_t addr_diwstop  = reg_addr_t'(9'h090 >> 1);
  localparam reg_addr_t addr_bplcon0  = reg_addr_t'(9'h100 >> 1);
  localparam reg_addr_t addr_bplcon2  = reg_addr_t'(9'h104 >> 1);
  localparam reg_addr_t addr_bpl1dat  = reg_addr_t'(9'h110 >> 1);
  localparam reg_addr_t addr_bpl6dat  = reg_addr_t'(9'h11a >> 1);  // last plane word
  localparam reg_addr_t addr_color00  = reg_addr_t'(9'h180 >> 1);
  localparam reg_addr_t addr_color31  = reg_addr_t'(9'h1be >> 1);

  // ----------------------------------------------------------
  // structs
  // ----------------------------------------------------------
  // wishbone classic request, driven by the outside master
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    reg_addr_t adr;
    word_t     dat;
  } wb_req_t;

  // one-cycle write strobe, valid on the ack cycle
  typedef struct packed {
    logic      valid;
    reg_addr_t adr;
    word_t     dat;
  } reg_wr_t;

  // decoded video control bits
  typedef struct packed {
    bpu_t bpu;     // bplcon0[14:12]
    logic dpf;     // bplcon0[10]
    logic pf2pri;  // bplcon2[6]
  } vid_ctrl_t;

endpackage
